/* src/apb_bus_pkg.sv */
package apb_bus_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------

  // AHB and APB address width
  localparam int ADDR_W = 16;
  // Word-wide data on both buses
  localparam int DATA_W = 32;

  // ------------------------------------------------------------
  // AHB control field codes
  // ------------------------------------------------------------

  localparam int HTRANS_W = 2;
  localparam int HSIZE_W  = 3;

  // HTRANS[1] set for NONSEQ and SEQ
  localparam int HTRANS_NONSEQ_BIT = 1;

  // Size codes that drive the endian swap controls
  localparam logic [HSIZE_W-1:0] HSIZE_HALF = 3'b001;
  localparam logic [HSIZE_W-1:0] HSIZE_WORD = 3'b010;

  // ------------------------------------------------------------
  // Bridge phases
  // ------------------------------------------------------------

  // Respond carries data or the first error cycle
  typedef enum logic [2:0] {
    BR_IDLE,
    BR_SETUP,
    BR_ACCESS,
    BR_RESPOND,
    BR_ERR2
  } bridge_state_t;

endpackage

/* src/periph_map_pkg.sv */
package periph_map_pkg;

  // ------------------------------------------------------------
  // Slot map
  // ------------------------------------------------------------

  // Register blocks present behind the bridge
  localparam int NUM_SLOTS = 4;

  // Slot number sits in the upper address nibble
  localparam int SLOT_FIELD_LSB = 12;
  localparam int SLOT_FIELD_W   = 4;

  // ------------------------------------------------------------
  // Register offsets within one slot
  // ------------------------------------------------------------

  // Byte offset field below the slot number
  localparam int REG_OFFSET_W = 12;

  // Read-only identification
  localparam logic [REG_OFFSET_W-1:0] REG_ID_OFFSET = 12'h000;
  // Read/write data word
  localparam logic [REG_OFFSET_W-1:0] REG_DATA_OFFSET = 12'h004;

  // ------------------------------------------------------------
  // Identification values
  // ------------------------------------------------------------

  // Slot n reports this base plus n
  localparam logic [31:0] SLOT_ID_BASE = 32'h00FA_50C0;

endpackage

/* src/apb_if.sv */
`timescale 1ns/1ps

interface apb_if;
  import apb_bus_pkg::*;

  // Request from the bridge, one common select
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;

  // Response from the read mux
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  modport bridge (output psel, penable, pwrite, paddr, pwdata,
                  input  prdata, pready, pslverr);

  // Slot field decode only
  modport decoder (input paddr, psel);

  // Per-slot select arrives separately
  modport slot (input paddr, penable, pwrite, pwdata);

  modport mux (output prdata, pready, pslverr);

endinterface

/* src/ahb_endian_swap.sv */
`timescale 1ns/1ps

module ahb_endian_swap #(
  parameter bit BIG_ENDIAN = 1'b0
) (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  // Address-phase qualifier and size
  input  logic                             i_sel_active,
  input  logic [apb_bus_pkg::HSIZE_W-1:0]  i_hsize,
  // Write path, AHB to bridge
  input  logic [apb_bus_pkg::DATA_W-1:0]   i_hwdata,
  output logic [apb_bus_pkg::DATA_W-1:0]   o_hwdata_le,
  // Read path, bridge to AHB
  input  logic [apb_bus_pkg::DATA_W-1:0]   i_hrdata_le,
  output logic [apb_bus_pkg::DATA_W-1:0]   o_hrdata
);
  import apb_bus_pkg::*;

  // Bit 1 exchanges half-words, bit 0 swaps bytes in each half
  logic [1:0] swap_q;
  logic [1:0] swap_nxt;

  // Same reordering in both directions
  function automatic logic [DATA_W-1:0] swap_word(input logic [DATA_W-1:0] d,
                                                 input logic [1:0]        ctrl);
    logic [DATA_W-1:0] b;
    b = ctrl[0] ? {d[23:16], d[31:24], d[7:0], d[15:8]} : d;
    return ctrl[1] ? {b[15:0], b[31:16]} : b;
  endfunction

  // Any size above a byte swaps within halves
  assign swap_nxt[0] = BIG_ENDIAN && ((i_hsize == HSIZE_HALF) || (i_hsize == HSIZE_WORD));
  // Only a word exchanges its halves
  assign swap_nxt[1] = BIG_ENDIAN && (i_hsize == HSIZE_WORD);

  // Held for the whole data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      swap_q <= 2'b00;
    else if (i_sel_active)
      swap_q <= swap_nxt;
  end

  assign o_hwdata_le = swap_word(i_hwdata, swap_q);
  assign o_hrdata    = swap_word(i_hrdata_le, swap_q);

endmodule

/* src/ahb_to_apb_bridge.sv */
`timescale 1ns/1ps

module ahb_to_apb_bridge (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  // AHB slave side
  input  logic                              i_hsel,
  input  logic [apb_bus_pkg::ADDR_W-1:0]    i_haddr,
  input  logic [apb_bus_pkg::HTRANS_W-1:0]  i_htrans,
  input  logic                              i_hwrite,
  input  logic                              i_hready,
  input  logic [apb_bus_pkg::DATA_W-1:0]    i_hwdata,
  output logic                              o_hreadyout,
  output logic [apb_bus_pkg::DATA_W-1:0]    o_hrdata,
  output logic                              o_hresp,
  // APB master side
  apb_if.bridge                             apb
);
  import apb_bus_pkg::*;

  bridge_state_t     state_q;
  bridge_state_t     state_nxt;
  logic              accept;
  logic              access_done;
  logic [ADDR_W-1:0] addr_q;
  logic              write_q;
  logic              err_q;
  logic [DATA_W-1:0] rdata_q;

  // Valid AHB address phase for this slave
  assign accept = i_hsel & i_htrans[HTRANS_NONSEQ_BIT] & i_hready;

  // Last access cycle
  assign access_done = (state_q == BR_ACCESS) & apb.pready;

  // ------------------------------------------------------------
  // Phase sequencing
  // ------------------------------------------------------------
  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      BR_IDLE:    state_nxt = accept ? BR_SETUP : BR_IDLE;
      BR_SETUP:   state_nxt = BR_ACCESS;
      // Wait states until the slot is ready
      BR_ACCESS:  state_nxt = apb.pready ? BR_RESPOND : BR_ACCESS;
      BR_RESPOND:
      begin
        if (err_q)
          state_nxt = BR_ERR2;
        else
          state_nxt = accept ? BR_SETUP : BR_IDLE;
      end
      // Next address phase may overlap the final error cycle
      BR_ERR2:    state_nxt = accept ? BR_SETUP : BR_IDLE;
      default:    state_nxt = BR_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q <= BR_IDLE;
      write_q <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_nxt;
      if (accept)
        write_q <= i_hwrite;
      if (access_done)
        err_q <= apb.pslverr;
    end
  end

  // Address and read data
  always_ff @(posedge HCLK)
  begin
    if (accept)
      addr_q <= i_haddr;
    if (access_done)
      rdata_q <= apb.prdata;
  end

  // ------------------------------------------------------------
  // Bus outputs
  // ------------------------------------------------------------
  assign apb.psel    = (state_q == BR_SETUP) || (state_q == BR_ACCESS);
  assign apb.penable = (state_q == BR_ACCESS);
  assign apb.paddr   = addr_q;
  assign apb.pwrite  = write_q;
  // HWDATA held by the master while the data phase is stretched
  assign apb.pwdata  = i_hwdata;

  // Low through setup and access, and in the first error cycle
  assign o_hreadyout = (state_q == BR_IDLE) || (state_q == BR_ERR2) ||
                       ((state_q == BR_RESPOND) && !err_q);
  assign o_hresp     = ((state_q == BR_RESPOND) && err_q) || (state_q == BR_ERR2);
  assign o_hrdata    = rdata_q;

endmodule

/* src/apb_slot_decoder.sv */
`timescale 1ns/1ps

module apb_slot_decoder (
  // Shared request
  apb_if.decoder                              apb,
  // One select per slot
  output logic [periph_map_pkg::NUM_SLOTS-1:0] o_slot_sel
);
  import periph_map_pkg::*;

  logic [SLOT_FIELD_W-1:0] slot_num;

  // Upper nibble of the APB address
  assign slot_num = apb.paddr[SLOT_FIELD_LSB +: SLOT_FIELD_W];

  // ------------------------------------------------------------
  // One-hot decode
  // ------------------------------------------------------------
  always_comb
  begin
    o_slot_sel = '0;
    for (int n = 0; n < NUM_SLOTS; n++)
    begin
      // Numbers past the last slot leave every bit low
      if (apb.psel && (slot_num == SLOT_FIELD_W'(n)))
        o_slot_sel[n] = 1'b1;
    end
  end

endmodule

/* src/apb_reg_slot.sv */
`timescale 1ns/1ps

module apb_reg_slot #(
  parameter logic [apb_bus_pkg::DATA_W-1:0] SLOT_ID = '0
) (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  // Shared request and own select
  apb_if.slot                             apb,
  input  logic                            i_sel,
  // Response toward the read mux
  output logic [apb_bus_pkg::DATA_W-1:0]  o_prdata,
  output logic                            o_pready,
  output logic                            o_pslverr,
  // Data register contents
  output logic [apb_bus_pkg::DATA_W-1:0]  o_data
);
  import apb_bus_pkg::*;
  import periph_map_pkg::*;

  logic [REG_OFFSET_W-1:0] offset;
  logic                    hit_id;
  logic                    hit_data;
  logic                    wr_access;
  logic [DATA_W-1:0]       data_q;

  // ------------------------------------------------------------
  // Register decode
  // ------------------------------------------------------------
  assign offset   = apb.paddr[REG_OFFSET_W-1:0];
  assign hit_id   = (offset == REG_ID_OFFSET);
  assign hit_data = (offset == REG_DATA_OFFSET);

  // Write lands in the access cycle
  assign wr_access = i_sel & apb.penable & apb.pwrite;

  // ------------------------------------------------------------
  // Data register
  // ------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      data_q <= '0;
    else if (wr_access && hit_data)
      data_q <= apb.pwdata;
  end

  // ------------------------------------------------------------
  // Read path
  // ------------------------------------------------------------
  always_comb
  begin
    o_prdata = '0;
    if (i_sel && !apb.pwrite)
    begin
      if (hit_id)
        o_prdata = SLOT_ID;
      else if (hit_data)
        o_prdata = data_q;
    end
  end

  // No wait states
  assign o_pready  = 1'b1;
  // ID register is read-only
  assign o_pslverr = wr_access & hit_id;
  assign o_data    = data_q;

endmodule

/* src/apb_read_mux.sv */
`timescale 1ns/1ps

module apb_read_mux (
  // Response back to the bridge
  apb_if.mux                                   apb,
  // Selects from the decoder
  input  logic [periph_map_pkg::NUM_SLOTS-1:0] i_slot_sel,
  // Slot responses by slot number
  input  logic [apb_bus_pkg::DATA_W-1:0]       i_prdata [periph_map_pkg::NUM_SLOTS],
  input  logic [periph_map_pkg::NUM_SLOTS-1:0] i_pready,
  input  logic [periph_map_pkg::NUM_SLOTS-1:0] i_pslverr
);
  import apb_bus_pkg::*;
  import periph_map_pkg::*;

  // ------------------------------------------------------------
  // Response select
  // ------------------------------------------------------------
  always_comb
  begin
    // Unmapped slot, ready at once with an error
    apb.prdata  = '0;
    apb.pready  = 1'b1;
    apb.pslverr = 1'b1;
    for (int n = 0; n < NUM_SLOTS; n++)
    begin
      if (i_slot_sel[n])
      begin
        apb.prdata  = i_prdata[n];
        apb.pready  = i_pready[n];
        apb.pslverr = i_pslverr[n];
      end
    end
  end

endmodule

/* src/apb_subsystem.sv */
`timescale 1ns/1ps

module apb_subsystem #(
  parameter bit BIG_ENDIAN = 1'b0
) (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  // AHB slave port
  input  logic                              i_hsel,
  input  logic [apb_bus_pkg::ADDR_W-1:0]    i_haddr,
  input  logic [apb_bus_pkg::HTRANS_W-1:0]  i_htrans,
  input  logic                              i_hwrite,
  input  logic [apb_bus_pkg::HSIZE_W-1:0]   i_hsize,
  input  logic                              i_hready,
  input  logic [apb_bus_pkg::DATA_W-1:0]    i_hwdata,
  output logic                              o_hreadyout,
  output logic [apb_bus_pkg::DATA_W-1:0]    o_hrdata,
  output logic                              o_hresp,
  // Slot 0 data register
  output logic [apb_bus_pkg::DATA_W-1:0]    o_gpio
);
  import apb_bus_pkg::*;
  import periph_map_pkg::*;

  logic                 sel_active;
  logic [DATA_W-1:0]    hwdata_le;
  logic [DATA_W-1:0]    hrdata_le;
  logic [NUM_SLOTS-1:0] slot_sel;
  logic [DATA_W-1:0]    slot_prdata [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] slot_pready;
  logic [NUM_SLOTS-1:0] slot_pslverr;
  logic [DATA_W-1:0]    slot_data [NUM_SLOTS];

  apb_if apb ();

  // Address phase that loads the swap control
  assign sel_active = i_hsel & i_htrans[HTRANS_NONSEQ_BIT] & i_hready;

  // ------------------------------------------------------------
  // AHB side
  // ------------------------------------------------------------
  ahb_endian_swap #(
    .BIG_ENDIAN (BIG_ENDIAN)
  ) u_endian_swap (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_sel_active (sel_active),
    .i_hsize      (i_hsize),
    .i_hwdata     (i_hwdata),
    .o_hwdata_le  (hwdata_le),
    .i_hrdata_le  (hrdata_le),
    .o_hrdata     (o_hrdata)
  );

  ahb_to_apb_bridge u_bridge (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hready    (i_hready),
    .i_hwdata    (hwdata_le),
    .o_hreadyout (o_hreadyout),
    .o_hrdata    (hrdata_le),
    .o_hresp     (o_hresp),
    .apb         (apb)
  );

  // ------------------------------------------------------------
  // APB side
  // ------------------------------------------------------------
  apb_slot_decoder u_decoder (
    .apb        (apb),
    .o_slot_sel (slot_sel)
  );

  // Identical register blocks, ID offset by slot number
  for (genvar i = 0; i < NUM_SLOTS; i++)
  begin : gen_slot
    apb_reg_slot #(
      .SLOT_ID (SLOT_ID_BASE + DATA_W'(i))
    ) u_slot (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .apb       (apb),
      .i_sel     (slot_sel[i]),
      .o_prdata  (slot_prdata[i]),
      .o_pready  (slot_pready[i]),
      .o_pslverr (slot_pslverr[i]),
      .o_data    (slot_data[i])
    );
  end

  apb_read_mux u_read_mux (
    .apb        (apb),
    .i_slot_sel (slot_sel),
    .i_prdata   (slot_prdata),
    .i_pready   (slot_pready),
    .i_pslverr  (slot_pslverr)
  );

  // GPIO mirrors the first slot
  assign o_gpio = slot_data[0];

endmodule

/* tb/apb_subsystem_sva.sv */
`timescale 1ns/1ps

module apb_subsystem_sva (
  input  logic                            HCLK,
  input  logic                            HRESETn,
  // APB request and ready as seen inside the DUT
  input  logic                            i_psel,
  input  logic                            i_penable,
  input  logic                            i_pwrite,
  input  logic                            i_pready,
  input  logic [apb_bus_pkg::ADDR_W-1:0]  i_paddr
);
  import apb_bus_pkg::*;

  // Setup phase comes first
  assert property (@(posedge HCLK) disable iff (!HRESETn)
                   $rose(i_psel) |-> !i_penable)
    else $error("APB select rose together with enable");

  // Enable only inside a selected transfer
  assert property (@(posedge HCLK) disable iff (!HRESETn)
                   i_penable |-> i_psel)
    else $error("APB enable high without select");

  // Held from setup through the last access cycle
  assert property (@(posedge HCLK) disable iff (!HRESETn)
                   (i_psel && !(i_penable && i_pready)) |=>
                   ($stable(i_paddr) && $stable(i_pwrite)))
    else $error("APB address or direction changed inside a transfer");

endmodule

/* tb/tb_apb_subsystem.sv */
`timescale 1ns/1ps

module tb_apb_subsystem;
  import apb_bus_pkg::*;
  import periph_map_pkg::*;

  localparam int TIMEOUT = 20;

  logic              HCLK;
  logic              HRESETn;
  logic              hsel;
  logic [ADDR_W-1:0] haddr;
  logic [1:0]        htrans;
  logic              hwrite;
  logic [2:0]        hsize;
  logic              hready;
  logic [DATA_W-1:0] hwdata;
  logic              hreadyout;
  logic [DATA_W-1:0] hrdata;
  logic              hresp;
  logic [DATA_W-1:0] gpio;

  // Bookkeeping
  int          seed = 63;
  int          errors;
  int          timeouts;
  int          tests;
  int          data_cycles;
  int          resp_cycles;
  string       cur_test;
  logic [DATA_W-1:0] exp_data [NUM_SLOTS];

  apb_subsystem #(
    .BIG_ENDIAN (1'b1)
  ) uut (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_hsel      (hsel),
    .i_haddr     (haddr),
    .i_htrans    (htrans),
    .i_hwrite    (hwrite),
    .i_hsize     (hsize),
    .i_hready    (hready),
    .i_hwdata    (hwdata),
    .o_hreadyout (hreadyout),
    .o_hrdata    (hrdata),
    .o_hresp     (hresp),
    .o_gpio      (gpio)
  );

  // Protocol checks on the internal APB bundle
  bind apb_subsystem apb_subsystem_sva u_sva (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .i_psel    (apb.psel),
    .i_penable (apb.penable),
    .i_pwrite  (apb.pwrite),
    .i_pready  (apb.pready),
    .i_paddr   (apb.paddr)
  );

  // 40 ns period
  always #20 HCLK = ~HCLK;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // Full byte reversal of a big-endian word
  function automatic logic [DATA_W-1:0] byte_reverse(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] r;
    for (int b = 0; b < DATA_W / 8; b++)
      r[8*b +: 8] = d[DATA_W - 8 - 8*b +: 8];
    return r;
  endfunction

  function automatic logic [ADDR_W-1:0] reg_addr(input int slot, input int offset);
    return ADDR_W'((slot << SLOT_FIELD_LSB) | offset);
  endfunction

  task automatic compare(input string what, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
    assert (act === exp)
    else
    begin
      $display("error %s: %s expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // One non-pipelined transfer with a stretched data phase
  task automatic bus_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
    @(negedge HCLK);
    hsel   = 1'b1;
    htrans = 2'b10;
    haddr  = addr;
    hwrite = wr;
    hsize  = HSIZE_WORD;
    @(negedge HCLK);
    // Address-phase signals move on while the data phase runs
    hsel        = 1'b0;
    htrans      = 2'b00;
    haddr       = ~addr;
    hwrite      = ~wr;
    hsize       = 3'b000;
    hwdata      = wdata;
    data_cycles = 1;
    resp_cycles = 0;
    while (!hreadyout && data_cycles < TIMEOUT)
    begin
      if (hresp)
        resp_cycles++;
      @(negedge HCLK);
      data_cycles++;
    end
    if (hresp)
      resp_cycles++;
    if (!hreadyout)
    begin
      $display("timeout: HREADYOUT stayed low in test %s at address %h", cur_test, addr);
      timeouts++;
    end
    rdata = hrdata;
    err   = hresp;
  endtask

  task automatic ahb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           output logic err);
    logic [DATA_W-1:0] unused;
    bus_transfer(1'b1, addr, wdata, unused, err);
  endtask

  task automatic ahb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata,
                          output logic err);
    bus_transfer(1'b0, addr, '0, rdata, err);
  endtask

  // Normal response takes 3 cycles and an error 4 with two HRESP cycles
  task automatic expect_response(input logic err, input logic exp_err);
    compare("error flag", DATA_W'(exp_err), DATA_W'(err));
    compare("data phase cycles", exp_err ? 4 : 3, data_cycles);
    compare("HRESP cycles", exp_err ? 2 : 0, resp_cycles);
  endtask

  task automatic report_test(input int start_errors);
    tests++;
    $display("test %s finished with %0d errors", cur_test, errors - start_errors);
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic reset_state();
    int start;
    start    = errors;
    cur_test = "reset_state";
    @(negedge HCLK);
    compare("o_gpio", '0, gpio);
    compare("HREADYOUT", 1, hreadyout);
    compare("HRESP", 0, hresp);
    report_test(start);
  endtask

  task automatic id_readback();
    int                start;
    logic [DATA_W-1:0] rd;
    logic              err;
    start    = errors;
    cur_test = "id_readback";
    for (int n = 0; n < NUM_SLOTS; n++)
    begin
      ahb_read(reg_addr(n, REG_ID_OFFSET), rd, err);
      expect_response(err, 1'b0);
      compare("slot ID", byte_reverse(SLOT_ID_BASE + DATA_W'(n)), rd);
    end
    report_test(start);
  endtask

  task automatic data_round_trip();
    int                start;
    logic [DATA_W-1:0] rd;
    logic              err;
    start    = errors;
    cur_test = "data_round_trip";
    for (int n = 0; n < NUM_SLOTS; n++)
    begin
      exp_data[n] = $random(seed);
      ahb_write(reg_addr(n, REG_DATA_OFFSET), exp_data[n], err);
      expect_response(err, 1'b0);
    end
    for (int n = 0; n < NUM_SLOTS; n++)
    begin
      ahb_read(reg_addr(n, REG_DATA_OFFSET), rd, err);
      expect_response(err, 1'b0);
      compare("data register", exp_data[n], rd);
    end
    // Register holds little-endian order
    compare("o_gpio", byte_reverse(exp_data[0]), gpio);
    report_test(start);
  endtask

  task automatic read_only_write();
    int                start;
    logic [DATA_W-1:0] rd;
    logic              err;
    start    = errors;
    cur_test = "read_only_write";
    ahb_write(reg_addr(1, REG_ID_OFFSET), $random(seed), err);
    expect_response(err, 1'b1);
    ahb_read(reg_addr(1, REG_ID_OFFSET), rd, err);
    expect_response(err, 1'b0);
    compare("slot ID", byte_reverse(SLOT_ID_BASE + 1), rd);
    ahb_read(reg_addr(1, REG_DATA_OFFSET), rd, err);
    compare("data register", exp_data[1], rd);
    report_test(start);
  endtask

  task automatic unmapped_slot();
    int                start;
    int                slot;
    logic [DATA_W-1:0] rd;
    logic              err;
    start    = errors;
    cur_test = "unmapped_slot";
    // First missing slot and the top of the field
    for (int k = 0; k < 2; k++)
    begin
      slot = (k == 0) ? NUM_SLOTS : (1 << SLOT_FIELD_W) - 1;
      ahb_write(reg_addr(slot, REG_DATA_OFFSET), $random(seed), err);
      expect_response(err, 1'b1);
      ahb_read(reg_addr(slot, REG_DATA_OFFSET), rd, err);
      expect_response(err, 1'b1);
    end
    for (int n = 0; n < NUM_SLOTS; n++)
    begin
      ahb_read(reg_addr(n, REG_DATA_OFFSET), rd, err);
      compare("data register", exp_data[n], rd);
    end
    compare("o_gpio", byte_reverse(exp_data[0]), gpio);
    report_test(start);
  endtask

  // ------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------
  initial
  begin
    HCLK     = 1'b0;
    HRESETn  = 1'b0;
    hsel     = 1'b0;
    haddr    = '0;
    htrans   = 2'b00;
    hwrite   = 1'b0;
    hsize    = HSIZE_WORD;
    hready   = 1'b1;
    hwdata   = '0;
    errors   = 0;
    timeouts = 0;
    tests    = 0;
    repeat (4) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    reset_state();
    id_readback();
    data_round_trip();
    read_only_write();
    unmapped_slot();

    $display("%0d tests run, %0d checks failed, %0d timeouts", tests, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* filelist.f */
src/apb_bus_pkg.sv
src/periph_map_pkg.sv
src/apb_if.sv
src/ahb_endian_swap.sv
src/ahb_to_apb_bridge.sv
src/apb_slot_decoder.sv
src/apb_reg_slot.sv
src/apb_read_mux.sv
src/apb_subsystem.sv
tb/apb_subsystem_sva.sv
tb/tb_apb_subsystem.sv

/* Bender.yml */
package:
  name: apb_subsystem

sources:
  - src/apb_bus_pkg.sv
  - src/periph_map_pkg.sv
  - src/apb_if.sv
  - src/ahb_endian_swap.sv
  - src/ahb_to_apb_bridge.sv
  - src/apb_slot_decoder.sv
  - src/apb_reg_slot.sv
  - src/apb_read_mux.sv
  - src/apb_subsystem.sv
  - target: test
    files:
      - tb/apb_subsystem_sva.sv
      - tb/tb_apb_subsystem.sv
